/* verification/spi_cases.txt */
// columns, all hex: divider, byte count, crc flag, bytes pushed, then the pushed bytes
// one case per line, a line with divider 0 ends the list
1 1 0 1 a5
2 4 0 4 01 23 45 67
3 5 1 5 40 00 00 00 00
1 5 1 5 48 00 00 01 aa
2 8 0 3 de ad be
1 4 1 0
4 3 0 0
1 10 0 10 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
2 f 1 f 0f 1e 2d 3c 4b 5a 69 78 87 96 a5 b4 c3 d2 e1
5 1 1 1 00
1 2 0 2 80 01
3 6 1 4 7e 81 c3 3c
1 10 0 10 ff fe fd fc fb fa f9 f8 f7 f6 f5 f4 f3 f2 f1 f0
2 3 1 3 77 00 41
1 1 0 0
6 2 1 2 69 00
1 7 0 7 55 aa 55 aa 01 02 04
2 c 1 a 40 00 00 00 00 95 ff 12 34 56
3 9 0 9 11 22 44 88 10 20 40 80 01
0 0 0 0

/* vlog.f */
source/spi_pkg.sv
source/apb_slave_port.sv
source/sync_fifo.sv
source/spi_sd_engine.sv
source/apb_spi.sv
verification/tb_apb_spi.sv

/* verification/tb_apb_spi.sv */
/*
  Testbench for the APB SPI master, with o_mosi looped back to i_miso.
  Cases come from verification/spi_cases.txt, read from the project root.
  Every case must fit the 16 entry FIFOs, count plus crc byte at most 16.
*/
`timescale 1ns/1ps

module tb_apb_spi;

    import spi_pkg::*;

    localparam int APB_TIMEOUT = 8;     // cycles to wait for o_pready
    localparam int POLL_LIMIT = 2000;   // CTRL reads per transfer
    localparam int CASE_WORDS = 512;

    logic        i_clk;
    logic        i_nrst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        cs_n;
    logic        sclk;
    logic        mosi;
    logic        detected;
    logic        protect;

    logic [31:0] case_mem [CASE_WORDS];
    logic [31:0] lfsr_q;
    logic        sclk_prev;
    int          sclk_rises;

    apb_spi dut0 (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_psel(psel),
        .i_penable(penable),
        .i_pwrite(pwrite),
        .i_paddr(paddr),
        .i_pwdata(pwdata),
        .o_prdata(prdata),
        .o_pready(pready),
        .o_pslverr(pslverr),
        .o_cs_n(cs_n),
        .o_sclk(sclk),
        .o_mosi(mosi),
        .i_miso(mosi),          // loopback
        .i_detected(detected),
        .i_protect(protect)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // count sclk rising edges while chip select is active
    always @(negedge i_clk) begin
        if (sclk && !sclk_prev && !cs_n) sclk_rises++;
        sclk_prev = sclk;
    end

    task automatic abort_run(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [6:0] crc7_byte(input logic [6:0] crc_in, input logic [7:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = crc_in;
        for (int i = 7; i >= 0; i--) begin
            fb = crc[6] ^ data[i];
            crc = {crc[5:0], 1'b0};
            if (fb) crc = crc ^ 7'h09;      // x^3 + 1
        end
        return crc;
    endfunction

    task automatic idle_gap();
        logic [1:0] gap;
        gap = {next_lfsr_bit(), next_lfsr_bit()};
        repeat (gap) @(negedge i_clk);
    endtask

    // one setup plus access phase, entered on a falling edge
    task automatic bus_cycle(input logic write, input logic [11:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        idle_gap();
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = {20'h0, addr};
        pwdata = wdata;
        @(negedge i_clk);
        penable = 1'b1;
        waited = 0;
        @(negedge i_clk);
        while (!pready) begin
            if (waited == APB_TIMEOUT) abort_run("timeout waiting for o_pready");
            waited++;
            @(negedge i_clk);
        end
        rdata = prdata;
        check_equal("o_pslverr", pslverr, 1'b0);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_transfer_done();
        logic [31:0] ctrl;
        int polls;
        polls = 0;
        apb_read(SPI_REG_CTRL, ctrl);
        while (ctrl[5:4] != SPI_IDLE || ctrl[31:16] != 16'd0) begin
            if (polls == POLL_LIMIT) abort_run("transfer did not return to idle in time");
            polls++;
            apb_read(SPI_REG_CTRL, ctrl);
        end
        check_equal("ctrl.crc", ctrl[7], 1'b0);     // crc byte consumed
    endtask

    logic [31:0] rd;
    logic [31:0] div;
    logic [15:0] count;
    logic        crc_on;
    logic [7:0]  exp_byte;
    logic [6:0]  crc;
    int          npush;
    int          idx;
    int          ncases;

    initial begin
        i_nrst = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        detected = 1'b1;
        protect = 1'b0;
        sclk_prev = 1'b1;
        sclk_rises = 0;
        lfsr_q = 32'hd0ad7fd0;
        $readmemh("verification/spi_cases.txt", case_mem);
        repeat (16) @(negedge i_clk);
        i_nrst = 1'b1;

        // idle pins and register values after reset
        check_equal("o_cs_n", cs_n, 1'b1);
        check_equal("o_sclk", sclk, 1'b1);
        check_equal("o_mosi", mosi, 1'b1);
        apb_read(SPI_REG_SCKDIV, rd);
        check_equal("sckdiv", rd, 32'h0);
        apb_read(SPI_REG_CTRL, rd);
        check_equal("ctrl", rd, {16'd0, 8'd0, 1'b0, 1'b0, 2'd0, 1'b0, 1'b1, 1'b0, 1'b1});
        apb_read(SPI_REG_RXDATA, rd);
        check_equal("rxdata.empty", rd[31], 1'b1);

        // divider keeps 31 bits
        apb_write(SPI_REG_SCKDIV, 32'hA5A5_5A5A);
        apb_read(SPI_REG_SCKDIV, rd);
        check_equal("sckdiv", rd, 32'h25A5_5A5A);
        apb_write(SPI_REG_SCKDIV, 32'hFFFF_FFFF);
        apb_read(SPI_REG_SCKDIV, rd);
        check_equal("sckdiv", rd, 32'h7FFF_FFFF);

        idx = 0;
        ncases = 0;
        while (!$isunknown(case_mem[idx]) && case_mem[idx] != 32'h0) begin
            div = case_mem[idx];
            count = case_mem[idx + 1][15:0];
            crc_on = case_mem[idx + 2][0];
            npush = case_mem[idx + 3];
            idx += 4;
            apb_write(SPI_REG_SCKDIV, div);
            for (int i = 0; i < npush; i++) apb_write(SPI_REG_TXDATA, case_mem[idx + i]);
            apb_read(SPI_REG_TXDATA, rd);
            check_equal("txdata.full", rd[31], npush == 16);
            sclk_rises = 0;
            apb_write(SPI_REG_CTRL, {count, 8'h00, crc_on, 7'h00});
            wait_transfer_done();
            check_equal("o_sclk rises", sclk_rises, 8 * (count + crc_on));

            // missing tx bytes go out as 0xFF
            crc = '0;
            for (int i = 0; i < count; i++) begin
                exp_byte = (i < npush) ? case_mem[idx + i][7:0] : 8'hFF;
                crc = crc7_byte(crc, exp_byte);
                apb_read(SPI_REG_RXDATA, rd);
                check_equal("rxdata.empty", rd[31], 1'b0);
                check_equal("rxdata.byte", rd[7:0], exp_byte);
            end
            if (crc_on) begin
                apb_read(SPI_REG_RXDATA, rd);
                check_equal("rxdata.empty", rd[31], 1'b0);
                check_equal("rxdata.crc", rd[7:0], {crc, 1'b1});
            end
            apb_read(SPI_REG_RXDATA, rd);
            check_equal("rxdata.empty", rd[31], 1'b1);
            idx += npush;
            ncases++;
        end

        if (ncases == 0) begin
            abort_run("no transfer cases were read from the data file");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* source/apb_spi.sv */
/*
  APB SPI master for SD cards. Registers at 0x00 (divider),
  0x44 (control/status), 0x48 (tx data) and 0x4C (rx data).
  Only address bits 11:0 are decoded. Reading RXDATA pops the head.
  Software checks TXDATA[31] before pushing, writes when full are lost.
*/
`timescale 1ns/1ps

module apb_spi (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [31:0] i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,
    output logic        o_cs_n,
    output logic        o_sclk,
    output logic        o_mosi,
    input  logic        i_miso,
    input  logic        i_detected,
    input  logic        i_protect
);

    import spi_pkg::*;

    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_write;
    logic [31:0] req_wdata;
    logic        resp_valid_q;
    logic [31:0] resp_rdata_q;
    logic [31:0] rdata;
    logic [11:0] reg_off;
    logic        wr_req;
    logic        rd_req;
    logic [30:0] scaler_q;

    logic        tx_wr_valid, tx_wr_ready;
    logic        tx_rd_valid, tx_rd_ready;
    logic [7:0]  tx_rd_data;
    logic        rx_wr_valid;
    logic        rx_rd_valid, rx_rd_ready;
    logic [7:0]  rx_wr_data, rx_rd_data;

    logic        eng_load;
    spi_state_e  eng_state;
    logic [15:0] eng_byte_count;
    logic        eng_crc;

    apb_slave_port pslv0 (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_psel(i_psel),
        .i_penable(i_penable),
        .i_pwrite(i_pwrite),
        .i_paddr(i_paddr),
        .i_pwdata(i_pwdata),
        .o_prdata(o_prdata),
        .o_pready(o_pready),
        .o_pslverr(o_pslverr),
        .o_req_valid(req_valid),
        .o_req_addr(req_addr),
        .o_req_write(req_write),
        .o_req_wdata(req_wdata),
        .i_resp_valid(resp_valid_q),
        .i_resp_rdata(resp_rdata_q)
    );

    assign reg_off = req_addr[11:0];
    assign wr_req = req_valid & req_write;
    assign rd_req = req_valid & ~req_write;

    assign tx_wr_valid = wr_req && (reg_off == SPI_REG_TXDATA);
    assign rx_rd_ready = rd_req && (reg_off == SPI_REG_RXDATA);    // pop on read
    assign eng_load = wr_req && (reg_off == SPI_REG_CTRL);

    sync_fifo txfifo (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_wr_valid(tx_wr_valid),
        .i_wr_data(req_wdata[7:0]),
        .o_wr_ready(tx_wr_ready),
        .o_rd_valid(tx_rd_valid),
        .o_rd_data(tx_rd_data),
        .i_rd_ready(tx_rd_ready)
    );

    sync_fifo rxfifo (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_wr_valid(rx_wr_valid),
        .i_wr_data(rx_wr_data),
        .o_wr_ready(),              // no back-pressure to the line
        .o_rd_valid(rx_rd_valid),
        .o_rd_data(rx_rd_data),
        .i_rd_ready(rx_rd_ready)
    );

    spi_sd_engine engine0 (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_scaler(scaler_q),
        .i_load(eng_load),
        .i_load_count(req_wdata[31:16]),
        .i_load_crc(req_wdata[7]),
        .o_state(eng_state),
        .o_byte_count(eng_byte_count),
        .o_crc_pending(eng_crc),
        .i_tx_valid(tx_rd_valid),
        .i_tx_data(tx_rd_data),
        .o_tx_ready(tx_rd_ready),
        .o_rx_valid(rx_wr_valid),
        .o_rx_data(rx_wr_data),
        .o_cs_n(o_cs_n),
        .o_sclk(o_sclk),
        .o_mosi(o_mosi),
        .i_miso(i_miso)
    );

    // read mux
    always_comb begin
        case (reg_off)
            SPI_REG_SCKDIV: rdata = {1'b0, scaler_q};
            SPI_REG_CTRL: rdata = {eng_byte_count, 8'h00, eng_crc, 1'b0, eng_state,
                                   1'b0, i_miso, i_protect, i_detected};
            SPI_REG_TXDATA: rdata = {~tx_wr_ready, 31'd0};          // full flag
            SPI_REG_RXDATA: rdata = {~rx_rd_valid, 23'd0, rx_rd_data};
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            resp_valid_q <= 1'b0;
            resp_rdata_q <= '0;
            scaler_q <= '0;
        end else begin
            resp_valid_q <= req_valid;
            resp_rdata_q <= rdata;
            if (wr_req && reg_off == SPI_REG_SCKDIV) begin
                scaler_q <= req_wdata[30:0];
            end
        end
    end

endmodule

/* source/spi_sd_engine.sv */
/*
  SPI mode 3 style byte engine for SD cards, MSB first.
  SCLK toggles every i_scaler clocks, a zero divider halts it.
  An empty tx FIFO sends 0xFF. Optional CRC7 byte (x^7+x^3+1)
  follows the data. Rx bytes are dropped when the rx FIFO is full.
*/
`timescale 1ns/1ps

module spi_sd_engine (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  logic [30:0]         i_scaler,
    input  logic                i_load,
    input  logic [15:0]         i_load_count,
    input  logic                i_load_crc,
    output spi_pkg::spi_state_e o_state,
    output logic [15:0]         o_byte_count,
    output logic                o_crc_pending,
    input  logic                i_tx_valid,
    input  logic [7:0]          i_tx_data,
    output logic                o_tx_ready,
    output logic                o_rx_valid,
    output logic [7:0]          o_rx_data,
    output logic                o_cs_n,
    output logic                o_sclk,
    output logic                o_mosi,
    input  logic                i_miso
);

    import spi_pkg::*;

    spi_state_e  state_q, state_d;
    logic [30:0] scaler_q;          // last divider, a change restarts the count
    logic [30:0] cnt_q, cnt_d;
    logic        level_q;
    logic        cs_q, cs_d;
    logic [15:0] byte_cnt_q, byte_cnt_d;
    logic        crc_en_q, crc_en_d;
    logic [2:0]  bit_cnt_q, bit_cnt_d;
    logic [7:0]  tx_shift_q, tx_shift_d;
    logic [7:0]  tx_val_q, tx_val_d;
    logic [7:0]  rx_shift_q, rx_shift_d;
    logic        rx_ready_q, rx_ready_d;
    logic [6:0]  crc7_q, crc7_d;
    logic        tick;
    logic        sclk_rise;
    logic        sclk_fall;
    logic        crc_fb;
    logic [6:0]  crc_next;
    logic [7:0]  next_byte;

    // clock scaler
    always_comb begin
        tick = 1'b0;
        cnt_d = cnt_q;
        if (i_scaler != scaler_q) begin
            cnt_d = '0;
        end else if (|i_scaler) begin
            if (cnt_q == i_scaler - 31'd1) begin
                cnt_d = '0;
                tick = 1'b1;
            end else begin
                cnt_d = cnt_q + 31'd1;
            end
        end
    end

    assign sclk_rise = tick & ~level_q;
    assign sclk_fall = tick & level_q;

    // crc7 over the bit currently on the line
    assign crc_fb = crc7_q[6] ^ tx_shift_q[7];
    assign crc_next = {crc7_q[5:3], crc7_q[2] ^ crc_fb, crc7_q[1:0], crc_fb};

    assign next_byte = i_tx_valid ? i_tx_data : 8'hFF;     // idle fill when fifo is dry

    always_comb begin
        state_d = state_q;
        cs_d = cs_q;
        byte_cnt_d = byte_cnt_q;
        crc_en_d = crc_en_q;
        bit_cnt_d = bit_cnt_q;
        tx_shift_d = tx_shift_q;
        tx_val_d = tx_val_q;
        rx_shift_d = rx_shift_q;
        rx_ready_d = rx_ready_q;
        crc7_d = crc7_q;
        o_tx_ready = 1'b0;

        // shift out on the falling edge
        if (sclk_fall && cs_q) begin
            tx_shift_d = {tx_shift_q[6:0], 1'b1};
            if (|bit_cnt_q) bit_cnt_d = bit_cnt_q - 3'd1;
            else cs_d = 1'b0;
        end

        // sample on the rising edge, flush the previous byte first
        if (sclk_rise) begin
            if (rx_ready_q) rx_ready_d = 1'b0;
            if (cs_q) begin
                rx_shift_d = {rx_shift_q[6:0], i_miso};
                crc7_d = crc_next;
            end
        end

        case (state_q)
            SPI_IDLE: begin
                if (|byte_cnt_q) begin
                    o_tx_ready = 1'b1;
                    tx_val_d = next_byte;
                    byte_cnt_d = byte_cnt_q - 16'd1;
                    crc7_d = '0;            // new transfer
                    state_d = SPI_WAIT_EDGE;
                end
            end
            SPI_WAIT_EDGE: begin
                if (sclk_fall) begin
                    cs_d = 1'b1;
                    bit_cnt_d = 3'd7;
                    tx_shift_d = tx_val_q;
                    state_d = SPI_SEND_DATA;
                end
            end
            SPI_SEND_DATA: begin
                if (bit_cnt_q == 3'd0 && sclk_rise) begin
                    if (|byte_cnt_q) begin
                        o_tx_ready = 1'b1;
                        tx_val_d = next_byte;
                        byte_cnt_d = byte_cnt_q - 16'd1;
                        state_d = SPI_WAIT_EDGE;
                    end else if (crc_en_q) begin
                        tx_val_d = {crc_next, 1'b1};    // crc includes this last bit
                        crc_en_d = 1'b0;
                        state_d = SPI_WAIT_EDGE;
                    end else begin
                        state_d = SPI_ENDING;
                    end
                    rx_ready_d = 1'b1;
                end
            end
            default: begin
                // hold until cs released and the last rx byte is out
                if (!cs_q && !rx_ready_q) state_d = SPI_IDLE;
            end
        endcase

        if (i_load) begin
            byte_cnt_d = i_load_count;
            crc_en_d = i_load_crc;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= SPI_IDLE;
            scaler_q <= '0;
            cnt_q <= '0;
            level_q <= 1'b1;            // sclk idles high
            cs_q <= 1'b0;
            byte_cnt_q <= '0;
            crc_en_q <= 1'b0;
            bit_cnt_q <= '0;
            tx_shift_q <= 8'hFF;        // mosi idles high
            rx_ready_q <= 1'b0;
            crc7_q <= '0;
        end else begin
            state_q <= state_d;
            scaler_q <= i_scaler;
            cnt_q <= cnt_d;
            level_q <= level_q ^ tick;
            cs_q <= cs_d;
            byte_cnt_q <= byte_cnt_d;
            crc_en_q <= crc_en_d;
            bit_cnt_q <= bit_cnt_d;
            tx_shift_q <= tx_shift_d;
            rx_ready_q <= rx_ready_d;
            crc7_q <= crc7_d;
        end
    end

    always_ff @(posedge i_clk) begin
        tx_val_q <= tx_val_d;
        rx_shift_q <= rx_shift_d;
    end

    assign o_state = state_q;
    assign o_byte_count = byte_cnt_q;
    assign o_crc_pending = crc_en_q;
    assign o_rx_valid = sclk_rise & rx_ready_q;
    assign o_rx_data = rx_shift_q;
    assign o_cs_n = ~cs_q;
    assign o_sclk = level_q;
    assign o_mosi = tx_shift_q[7];

    // chip select is only driven while a transfer is in flight
    a_cs_busy: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        !o_cs_n |-> (state_q != SPI_IDLE)
    );

endmodule

/* source/sync_fifo.sv */
/*
  First-word-fall-through byte FIFO, depth taken from spi_pkg.
  A write while full is dropped and a pop while empty is ignored.
  rd_data shows the head word before it is popped.
*/
`timescale 1ns/1ps

module sync_fifo (
    input  logic                               i_clk,
    input  logic                               i_nrst,
    input  logic                               i_wr_valid,
    input  logic [spi_pkg::SPI_FIFO_DBITS-1:0] i_wr_data,
    output logic                               o_wr_ready,
    output logic                               o_rd_valid,
    output logic [spi_pkg::SPI_FIFO_DBITS-1:0] o_rd_data,
    input  logic                               i_rd_ready
);

    import spi_pkg::*;

    localparam int DEPTH = 1 << SPI_FIFO_LOG2_DEPTH;
    localparam int AW = SPI_FIFO_LOG2_DEPTH;

    logic [SPI_FIFO_DBITS-1:0] mem [DEPTH];
    logic [AW:0] wr_ptr_q;     // extra msb tells full from empty
    logic [AW:0] rd_ptr_q;
    logic [AW:0] level;
    logic        full;
    logic        empty;
    logic        push;
    logic        pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign level = wr_ptr_q - rd_ptr_q;

    assign push = i_wr_valid & ~full;
    assign pop = i_rd_ready & ~empty;

    assign o_wr_ready = ~full;
    assign o_rd_valid = ~empty;
    assign o_rd_data = mem[rd_ptr_q[AW-1:0]];

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr_q[AW-1:0]] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // no overflow past the last entry
    a_no_overflow: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        level <= DEPTH
    );

    // read pointer only moves while a word is stored
    a_no_underflow: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (rd_ptr_q != $past(rd_ptr_q)) |-> ($past(level) != '0)
    );

endmodule

/* source/apb_slave_port.sv */
/*
  APB slave front end. Each access phase gives one request strobe.
  The response is expected one cycle after the strobe, so every
  transfer has exactly one wait state. PSLVERR is always zero.
*/
`timescale 1ns/1ps

module apb_slave_port (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [31:0] i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,
    output logic        o_req_valid,
    output logic [31:0] o_req_addr,
    output logic        o_req_write,
    output logic [31:0] o_req_wdata,
    input  logic        i_resp_valid,
    input  logic [31:0] i_resp_rdata
);

    logic        access;
    logic        issued_q;      // request already sent in this phase
    logic        done_q;        // response seen, phase still open
    logic [31:0] rdata_q;

    assign access = i_psel & i_penable;

    assign o_req_valid = access & ~issued_q;
    assign o_req_addr = i_paddr;
    assign o_req_write = i_pwrite;
    assign o_req_wdata = i_pwdata;

    // response stays visible until penable drops
    assign o_pready = access & (i_resp_valid | done_q);
    assign o_prdata = i_resp_valid ? i_resp_rdata : rdata_q;
    assign o_pslverr = 1'b0;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            issued_q <= 1'b0;
            done_q <= 1'b0;
            rdata_q <= '0;
        end else begin
            issued_q <= access;                 // cleared once penable falls
            done_q <= access & (i_resp_valid | done_q);
            if (i_resp_valid) begin
                rdata_q <= i_resp_rdata;
            end
        end
    end

    // the register file answers exactly one cycle after a strobe
    a_resp_follows_req: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_resp_valid |-> $past(o_req_valid)
    );

endmodule

/* source/spi_pkg.sv */
/*
  Shared constants and types for the APB SPI master for SD cards.
  Register offsets are byte offsets inside a 4 KB APB window.
  The FIFO depth is kept small so the full flag is reachable.
*/
package spi_pkg;

    // fifo geometry
    localparam int SPI_FIFO_LOG2_DEPTH = 4;     // 16 entries
    localparam int SPI_FIFO_DBITS = 8;

    // register map, byte offsets
    localparam logic [11:0] SPI_REG_SCKDIV = 12'h000;   // clock divider
    localparam logic [11:0] SPI_REG_CTRL = 12'h044;     // status, count, crc flag
    localparam logic [11:0] SPI_REG_TXDATA = 12'h048;   // tx fifo push
    localparam logic [11:0] SPI_REG_RXDATA = 12'h04C;   // rx fifo pop

    // transmit engine states, reported in CTRL[5:4]
    typedef enum logic [1:0] {
        SPI_IDLE = 2'd0,        // waiting for a byte count
        SPI_WAIT_EDGE = 2'd1,   // byte loaded, waiting for sclk fall
        SPI_SEND_DATA = 2'd2,   // shifting eight bits
        SPI_ENDING = 2'd3       // waiting for chip select release
    } spi_state_e;

endpackage
